// ==== src/video_pkg.sv ====
package video_pkg;

	typedef logic [8:0] pos_t;              // Screen coordinate
	typedef logic [2:0] rgb_t;              // Bit order {b, g, r}

	typedef struct packed {
		pos_t hpos;
		pos_t vpos;
		logic display_on;
		logic hsync;                        // Active low
		logic vsync;                        // Active low
	} beam_t;

	typedef struct packed {
		pos_t y;
		pos_t x;
	} sprite_pos_t;

	typedef struct packed {
		logic [9:0] spare;                  // Ignored
		rgb_t       bg;
		rgb_t       color;
		logic       flip_y;
		logic       enable;
	} sprite_attr_t;

	// Host write word, meaning depends on the register address
	typedef union packed {
		sprite_pos_t  pos;
		sprite_attr_t attr;
	} reg_word_u;

	typedef struct packed {
		sprite_pos_t  pos;
		sprite_attr_t attr;
	} sprite_cfg_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic display_on;
		rgb_t rgb;
	} video_out_t;

	parameter logic REG_POS  = 1'b0;
	parameter logic REG_ATTR = 1'b1;

	parameter pos_t SPRITE_SIZE = 9'd16;
	parameter int   RENDER_LAT  = 2;        // Beam to video delay in cycles

endpackage

// ==== src/video_timing.sv ====
`timescale 1ns/1ps

module video_timing import video_pkg::*; #(
	parameter pos_t H_DISPLAY,
	parameter pos_t H_SYNC_START,
	parameter pos_t H_SYNC_END,
	parameter pos_t H_TOTAL,
	parameter pos_t V_DISPLAY,
	parameter pos_t V_SYNC_START,
	parameter pos_t V_SYNC_END,
	parameter pos_t V_TOTAL
) (
	input  logic  clk25,
	input  logic  rst_n,
	output beam_t beam
);

	pos_t hpos;
	pos_t vpos;
	logic h_last;
	logic v_last;
	logic h_in_sync;
	logic v_in_sync;

	assign h_last = (hpos == H_TOTAL - 9'd1);    // Last pixel of the line
	assign v_last = (vpos == V_TOTAL - 9'd1);    // Last line of the frame

	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			hpos <= '0;
		end else if (h_last) begin
			hpos <= '0;
		end else begin
			hpos <= hpos + 9'd1;
		end
	end

	// Line counter steps once per line
	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			vpos <= '0;
		end else if (h_last) begin
			if (v_last) begin
				vpos <= '0;
			end else begin
				vpos <= vpos + 9'd1;
			end
		end
	end

	assign h_in_sync = (hpos >= H_SYNC_START) && (hpos < H_SYNC_END);
	assign v_in_sync = (vpos >= V_SYNC_START) && (vpos < V_SYNC_END);

	always_comb begin
		beam.hpos       = hpos;
		beam.vpos       = vpos;
		beam.display_on = (hpos < H_DISPLAY) && (vpos < V_DISPLAY);
		beam.hsync      = !h_in_sync;        // Low during the sync pulse
		beam.vsync      = !v_in_sync;
	end

endmodule

// ==== src/sprite_regs.sv ====
`timescale 1ns/1ps

module sprite_regs import video_pkg::*; (
	input  logic        clk25,
	input  logic        rst_n,
	input  logic        reg_wr,
	input  logic        reg_addr,
	input  reg_word_u   reg_wdata,
	input  beam_t       beam,
	output sprite_cfg_t cfg
);

	sprite_pos_t  pend_pos;
	sprite_attr_t pend_attr;
	logic         frame_start;

	// Beam sits on the first pixel of a frame
	assign frame_start = (beam.hpos == '0) && (beam.vpos == '0);

	// Host writes only touch the pending copy
	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			pend_pos  <= '0;
			pend_attr <= '0;
		end else if (reg_wr) begin
			if (reg_addr == REG_POS) begin
				pend_pos <= reg_wdata.pos;
			end else begin
				pend_attr <= reg_wdata.attr;      // REG_ATTR
			end
		end
	end

	// Active copy only moves at frame start, so a frame never tears.
	// A write landing in the same cycle waits for the next frame.
	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			cfg <= '0;                             // Disabled, black, at (0,0)
		end else if (frame_start) begin
			cfg.pos  <= pend_pos;
			cfg.attr <= pend_attr;
		end
	end

endmodule

// ==== src/sprite_rom.sv ====
`timescale 1ns/1ps

module sprite_rom (
	input  logic       clk25,
	input  logic [3:0] row,
	output logic [7:0] bits
);

	// Left half of the car, bit 0 is the outer column
	localparam logic [7:0] CAR_ROWS [0:15] = '{
		8'b0000_0000,
		8'b0000_1100,
		8'b1100_1100,
		8'b1111_1100,
		8'b1110_1100,
		8'b1110_0000,
		8'b0110_0000,
		8'b0111_0000,
		8'b0011_0000,
		8'b0011_0000,
		8'b0011_0000,
		8'b0110_1110,
		8'b1110_1110,
		8'b1111_1110,
		8'b1110_1110,
		8'b0010_1110
	};

	always_ff @(posedge clk25) begin
		bits <= CAR_ROWS[row];                     // Second render stage
	end

endmodule

// ==== src/sprite_render.sv ====
`timescale 1ns/1ps

module sprite_render import video_pkg::*; (
	input  logic        clk25,
	input  logic        rst_n,
	input  beam_t       beam,
	input  sprite_cfg_t cfg,
	output video_out_t  video
);

	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       display_on;
		logic       enable;
		logic       hit;
		logic [2:0] idx;                           // Bit within the ROM row
		rgb_t       color;
		rgb_t       bg;
	} stage1_t;

	pos_t       dx;
	pos_t       dy;
	logic       hit;
	logic [3:0] row;
	logic [2:0] idx;
	logic [7:0] rom_bits;
	stage1_t    s1;
	rgb_t       pix;

	// Offsets wrap modulo 512, anything left of or above the sprite is large
	assign dx  = beam.hpos - cfg.pos.x;
	assign dy  = beam.vpos - cfg.pos.y;
	assign hit = (dx < SPRITE_SIZE) && (dy < SPRITE_SIZE);

	assign row = cfg.attr.flip_y ? 4'd15 - dy[3:0] : dy[3:0];

	// Mirror the 8-bit row into 16 columns, columns 8..15 map to 7..0
	assign idx = dx[3] ? ~dx[2:0] : dx[2:0];

	sprite_rom rom0 (
		.clk25 (clk25),
		.row   (row),
		.bits  (rom_bits)
	);

	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			s1            <= '0;
			s1.hsync      <= 1'b1;                 // Syncs idle high
			s1.vsync      <= 1'b1;
		end else begin
			s1.hsync      <= beam.hsync;
			s1.vsync      <= beam.vsync;
			s1.display_on <= beam.display_on;
			s1.enable     <= cfg.attr.enable;
			s1.hit        <= hit;
			s1.idx        <= idx;
			s1.color      <= cfg.attr.color;
			s1.bg         <= cfg.attr.bg;
		end
	end

	// ROM row arrives together with the stage 1 registers
	always_comb begin
		if (!s1.display_on) begin
			pix = '0;                              // Blanking stays black
		end else if (s1.enable && s1.hit && rom_bits[s1.idx]) begin
			pix = s1.color;
		end else begin
			pix = s1.bg;
		end
	end

	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			video.hsync      <= 1'b1;
			video.vsync      <= 1'b1;
			video.display_on <= 1'b0;
			video.rgb        <= '0;
		end else begin
			video.hsync      <= s1.hsync;
			video.vsync      <= s1.vsync;
			video.display_on <= s1.display_on;
			video.rgb        <= pix;
		end
	end

endmodule

// ==== src/sprite_video_top.sv ====
`timescale 1ns/1ps

module sprite_video_top import video_pkg::*; #(
	parameter pos_t H_DISPLAY    = 9'd256,
	parameter pos_t H_SYNC_START = 9'd272,
	parameter pos_t H_SYNC_END   = 9'd304,
	parameter pos_t H_TOTAL      = 9'd320,
	parameter pos_t V_DISPLAY    = 9'd240,
	parameter pos_t V_SYNC_START = 9'd244,
	parameter pos_t V_SYNC_END   = 9'd247,
	parameter pos_t V_TOTAL      = 9'd262
) (
	input  logic       clk25,
	input  logic       rst_n,
	input  logic       reg_wr,                 // One write per high cycle
	input  logic       reg_addr,
	input  reg_word_u  reg_wdata,
	output video_out_t video
);

	beam_t       beam;
	sprite_cfg_t cfg;

	video_timing #(
		.H_DISPLAY    (H_DISPLAY),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_END   (H_SYNC_END),
		.H_TOTAL      (H_TOTAL),
		.V_DISPLAY    (V_DISPLAY),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_END   (V_SYNC_END),
		.V_TOTAL      (V_TOTAL)
	) timing0 (
		.clk25 (clk25),
		.rst_n (rst_n),
		.beam  (beam)
	);

	sprite_regs regs0 (
		.clk25     (clk25),
		.rst_n     (rst_n),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.beam      (beam),
		.cfg       (cfg)
	);

	// Two-cycle pipeline from beam to video
	sprite_render render0 (
		.clk25 (clk25),
		.rst_n (rst_n),
		.beam  (beam),
		.cfg   (cfg),
		.video (video)
	);

endmodule

// ==== bench/sprite_video_assert.sv ====
`timescale 1ns/1ps

module sprite_video_assert import video_pkg::*; #(
	parameter pos_t H_SYNC_START = 9'd272,
	parameter pos_t H_SYNC_END   = 9'd304
) (
	input logic        clk25,
	input logic        rst_n,
	input beam_t       beam,
	input sprite_cfg_t cfg,
	input video_out_t  video
);

	localparam int HSYNC_LEN = int'(H_SYNC_END - H_SYNC_START);

	int fail_cnt = 0;                        // Assertion failures so far
	int hs_low;                              // Cycles of the current hsync pulse

	always_ff @(posedge clk25) begin
		if (!rst_n) begin
			hs_low <= 0;
		end else if (!video.hsync) begin
			hs_low <= hs_low + 1;
		end else begin
			hs_low <= 0;
		end
	end

	// Blanking stays black
	blank_black: assert property (@(posedge clk25) disable iff (!rst_n)
		!video.display_on |-> video.rgb == '0)
		else begin
			$error("rgb is not black while display_on is low");
			fail_cnt++;
		end

	hsync_width: assert property (@(posedge clk25) disable iff (!rst_n)
		$rose(video.hsync) |-> hs_low == HSYNC_LEN)
		else begin
			$error("hsync pulse lasted %0d cycles", hs_low);
			fail_cnt++;
		end

	// Active registers only move right after pixel (0,0)
	cfg_frame_only: assert property (@(posedge clk25) disable iff (!rst_n)
		cfg != $past(cfg) |-> $past(beam.hpos == '0 && beam.vpos == '0))
		else begin
			$error("sprite configuration changed inside a frame");
			fail_cnt++;
		end

endmodule

bind sprite_video_top sprite_video_assert #(
	.H_SYNC_START (H_SYNC_START),
	.H_SYNC_END   (H_SYNC_END)
) chk0 (
	.clk25 (clk25),
	.rst_n (rst_n),
	.beam  (beam),
	.cfg   (cfg),
	.video (video)
);

// ==== bench/sprite_video_tb.sv ====
`timescale 1ns/1ps

module sprite_video_tb import video_pkg::*; ();

	localparam pos_t H_DISPLAY    = 9'd256;
	localparam pos_t H_SYNC_START = 9'd272;
	localparam pos_t H_SYNC_END   = 9'd304;
	localparam pos_t H_TOTAL      = 9'd320;
	localparam pos_t V_DISPLAY    = 9'd240;
	localparam pos_t V_SYNC_START = 9'd244;
	localparam pos_t V_SYNC_END   = 9'd247;
	localparam pos_t V_TOTAL      = 9'd262;

	// Seven frames of 320 x 262 plus a little slack for reset and the pipeline
	localparam int TIMEOUT_CYCLES = 7 * 320 * 262 + 120;

	// Syncs idle high and the picture black right after reset
	localparam video_out_t VIDEO_IDLE = '{
		hsync: 1'b1, vsync: 1'b1, display_on: 1'b0, rgb: 3'd0
	};

	// Left half of the car with bit 0 as the leftmost column
	localparam logic [7:0] CAR [16] = '{
		8'b0000_0000, 8'b0000_1100, 8'b1100_1100, 8'b1111_1100,
		8'b1110_1100, 8'b1110_0000, 8'b0110_0000, 8'b0111_0000,
		8'b0011_0000, 8'b0011_0000, 8'b0011_0000, 8'b0110_1110,
		8'b1110_1110, 8'b1111_1110, 8'b1110_1110, 8'b0010_1110
	};

	logic        clk25;
	logic        rst_n;
	logic        reg_wr;
	logic        reg_addr;
	reg_word_u   reg_wdata;
	video_out_t  video;

	pos_t         m_h;                       // Beam model
	pos_t         m_v;
	sprite_pos_t  m_pend_pos;                // Register model
	sprite_attr_t m_pend_attr;
	sprite_cfg_t  m_act;

	video_out_t exp_d1;
	video_out_t exp_d2;
	pos_t       h_d1;
	pos_t       v_d1;
	pos_t       h_d2;
	pos_t       v_d2;
	int         depth;
	int         errors = 0;
	int         tests_ok = 0;
	int         tests_bad = 0;
	int         cycle_cnt = 0;

	sprite_video_top dut0 (
		.clk25     (clk25),
		.rst_n     (rst_n),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.video     (video)
	);

	initial begin
		clk25 = 1'b0;
		forever #10 clk25 = ~clk25;          // 20 ns period
	end

	// Expected output for one beam position under a given configuration
	function automatic video_out_t pixel_ref(input pos_t h, input pos_t v,
	                                         input sprite_cfg_t c);
		video_out_t o;
		pos_t       dx;
		pos_t       dy;
		int         row;
		int         col;
		int         bit_idx;
		dx           = h - c.pos.x;           // 9-bit screen arithmetic
		dy           = v - c.pos.y;
		o.hsync      = !(h >= H_SYNC_START && h < H_SYNC_END);
		o.vsync      = !(v >= V_SYNC_START && v < V_SYNC_END);
		o.display_on = (h < H_DISPLAY) && (v < V_DISPLAY);
		o.rgb        = '0;
		if (o.display_on) begin
			o.rgb = c.attr.bg;
			if (c.attr.enable && dx < SPRITE_SIZE && dy < SPRITE_SIZE) begin
				row     = c.attr.flip_y ? 15 - int'(dy) : int'(dy);
				col     = int'(dx);
				bit_idx = (col < 8) ? col : 15 - col;    // Right half mirrors the left
				if (CAR[row[3:0]][bit_idx[2:0]]) begin
					o.rgb = c.attr.color;
				end
			end
		end
		return o;
	endfunction

	// Beam and register model on the same clock and reset as the DUT
	always @(posedge clk25) begin
		if (!rst_n) begin
			m_h         <= '0;
			m_v         <= '0;
			m_pend_pos  <= '0;
			m_pend_attr <= '0;
			m_act       <= '0;
		end else begin
			if (m_h == H_TOTAL - 9'd1) begin
				m_h <= '0;
				m_v <= (m_v == V_TOTAL - 9'd1) ? 9'd0 : m_v + 9'd1;
			end else begin
				m_h <= m_h + 9'd1;
			end
			if (m_h == 9'd0 && m_v == 9'd0) begin
				m_act.pos  <= m_pend_pos;      // Frame start
				m_act.attr <= m_pend_attr;
			end
			if (reg_wr) begin
				if (reg_addr == REG_POS) begin
					m_pend_pos <= reg_wdata.pos;
				end else begin
					m_pend_attr <= reg_wdata.attr;
				end
			end
		end
	end

	// Video of this cycle belongs to the beam two cycles back
	always @(negedge clk25) begin
		if (!rst_n) begin
			depth = 0;
		end else begin
			if (depth >= RENDER_LAT) begin
				assert (video == exp_d2) else begin
					errors++;
					$display("FAILED at %0t ns: pixel (%0d,%0d) got %h expected %h",
					         $time, h_d2, v_d2, video, exp_d2);
				end
			end else begin
				assert (video == VIDEO_IDLE) else begin
					errors++;
					$display("FAILED at %0t ns: video %h after reset, expected %h",
					         $time, video, VIDEO_IDLE);
				end
			end
			exp_d2 = exp_d1;
			h_d2   = h_d1;
			v_d2   = v_d1;
			exp_d1 = pixel_ref(m_h, m_v, m_act);
			h_d1   = m_h;
			v_d1   = m_v;
			if (depth < RENDER_LAT) begin
				depth++;
			end
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk25);
			cycle_cnt++;
		end
		$display("Run timed out after %0d cycles", cycle_cnt);
		$display("tests failed");
		$finish;
	end

	task automatic wait_beam(input pos_t h, input pos_t v);
		do begin
			@(posedge clk25);
			#1;
		end while (!(m_h == h && m_v == v));
	endtask

	task automatic write_reg(input logic addr, input reg_word_u word);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = word;
		@(posedge clk25);
		#1;
		reg_wr    = 1'b0;
	endtask

	task automatic write_pos(input sprite_pos_t p);
		reg_word_u w;
		w.pos = p;
		write_reg(REG_POS, w);
	endtask

	task automatic write_attr(input sprite_attr_t a);
		reg_word_u w;
		w.attr = a;
		write_reg(REG_ATTR, w);
	endtask

	task automatic pick_sprite(output sprite_pos_t p, output sprite_attr_t a);
		p.x      = pos_t'($urandom_range(0, 240));
		p.y      = pos_t'($urandom_range(0, 224));
		a        = '0;
		a.enable = 1'b1;
		a.color  = rgb_t'($urandom_range(1, 7));
		a.bg     = rgb_t'($urandom_range(0, 7));
		if (a.bg == a.color) begin
			a.bg = ~a.color;                  // Keep the sprite visible
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		if (errors == err_start) begin
			tests_ok++;
			$display("Test %s: passed", name);
		end else begin
			tests_bad++;
			$display("Test %s: %0d mismatching pixels", name, errors - err_start);
		end
	endtask

	initial begin
		sprite_pos_t  pos;
		sprite_attr_t attr;
		int           start;
		void'($urandom(32'h504c));
		rst_n     = 1'b0;
		reg_wr    = 1'b0;
		reg_addr  = 1'b0;
		reg_wdata = '0;
		repeat (5) @(posedge clk25);
		#1 rst_n = 1'b1;

		start = errors;                      // Frame 0 with nothing written yet
		wait_beam(9'd0, 9'd250);
		pick_sprite(pos, attr);
		write_pos(pos);
		write_attr(attr);
		wait_beam(9'd2, 9'd0);
		end_test("reset state", start);

		start = errors;                      // Frame 1 shows a random sprite
		wait_beam(9'd0, 9'd250);
		attr.flip_y = 1'b1;
		write_attr(attr);
		wait_beam(9'd2, 9'd0);
		end_test("random sprite", start);

		start = errors;                      // Frame 2 is flipped
		wait_beam(9'd2, 9'd0);
		end_test("vertical flip", start);

		start = errors;                      // Frames 3 and 4
		wait_beam(9'd0, 9'd120);
		pick_sprite(pos, attr);
		write_pos(pos);
		write_attr(attr);
		wait_beam(9'd2, 9'd0);
		wait_beam(9'd0, 9'd250);
		pos.x = 9'd250;
		pos.y = 9'd232;
		write_pos(pos);
		wait_beam(9'd2, 9'd0);
		end_test("mid-frame write", start);

		start = errors;                      // Frame 5 clips at the corner
		wait_beam(9'd0, 9'd250);
		attr.enable = 1'b0;
		attr.bg     = rgb_t'($urandom_range(1, 7));
		write_attr(attr);
		wait_beam(9'd2, 9'd0);
		end_test("edge clipping", start);

		start = errors;                      // Frame 6 is background only
		wait_beam(9'd2, 9'd0);
		end_test("disabled sprite", start);

		assert (dut0.chk0.fail_cnt == 0) begin
			tests_ok++;
			$display("Test bound assertions: passed");
		end else begin
			tests_bad++;
			$display("Test bound assertions: %0d failures", dut0.chk0.fail_cnt);
		end

		$display("Summary: %0d passed, %0d failed", tests_ok, tests_bad);
		if (tests_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
src/video_pkg.sv
src/video_timing.sv
src/sprite_regs.sv
src/sprite_rom.sv
src/sprite_render.sv
src/sprite_video_top.sv
bench/sprite_video_assert.sv
bench/sprite_video_tb.sv

// ==== Makefile ====
TOP := sprite_video_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
